/* run_sim.sh */
#!/bin/sh
# compile and run the SRAM bank testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_sram_bank \
  -f src.f -Mdir obj_dir -o tb_sram_bank > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sram_bank > sim.log 2>&1
cat sim.log
grep -qx "all tests passed" sim.log && exit 0 || exit 1

/* sram_access_ctrl.sv */
/*
  SRAM access control: posts writes into the data phase, arbitrates the array port
  and stalls a read that collides with a posted write for one cycle
*/
`timescale 1ns/1ps
`include "sram_params.svh"

module sram_access_ctrl
  import sram_pkg::*;
(
  input  logic       i_sys_hclk,
  input  logic       i_sys_rst_b,
  input  logic       i_hsel,
  input  htrans_t    i_htrans,
  input  logic       i_hwrite,
  input  hsize_t     i_hsize,
  input  baddr_t     i_haddr,
  input  logic       i_hready,
  output logic       o_ram_sel,
  output logic       o_ram_write,
  output hsize_t     o_ram_size,
  output baddr_t     o_ram_addr,
  output hsize_t     o_size_r,
  output logic [1:0] o_addr_lo_r,
  output logic       o_sel_r,
  output logic       o_bank_hready,
  output logic       o_idle
);

  logic   act;
  logic   rd_act;
  logic   wr_act;
  logic   collide;
  logic   pst_vld;
  logic   pst_write;
  logic   raw_stall;
  hsize_t pst_size;
  baddr_t pst_addr;

  assign act     = i_hsel & ((i_htrans == `HTRANS_NONSEQ) | (i_htrans == `HTRANS_SEQ)) & i_hready;
  assign rd_act  = act & ~i_hwrite;
  assign wr_act  = act & i_hwrite;
  assign collide = rd_act & pst_vld & pst_write;  // read meets posted write

  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
    begin
      pst_vld   <= 1'b0;
      pst_write <= 1'b0;
      raw_stall <= 1'b0;
    end
    else
    begin
      pst_vld   <= wr_act | collide;
      pst_write <= wr_act;  // low for a deferred read
      raw_stall <= collide;
    end
  end

  always_ff @(posedge i_sys_hclk)
  begin
    if (wr_act || collide)
    begin
      pst_size <= i_hsize;
      pst_addr <= i_haddr;
    end
  end

  // data-phase copy for the lane steerer
  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
      o_sel_r <= 1'b0;
    else if (i_hready)
      o_sel_r <= act;
  end

  always_ff @(posedge i_sys_hclk)
  begin
    if (i_hready)
    begin
      o_size_r    <= i_hsize;
      o_addr_lo_r <= i_haddr[1:0];
    end
  end

  // posted access owns the port
  assign o_ram_sel   = pst_vld | rd_act;
  assign o_ram_write = pst_vld & pst_write;
  assign o_ram_size  = pst_vld ? pst_size : i_hsize;
  assign o_ram_addr  = pst_vld ? pst_addr : i_haddr;

  assign o_bank_hready = ~raw_stall;
  assign o_idle        = ~act & ~pst_vld;

endmodule

/* sram_bank_top.sv */
/*
  SRAM bank top: AHB slave with region protection, posted writes,
  endian lane steering and a single-port word array
*/
`timescale 1ns/1ps

module sram_bank_top
  import sram_pkg::*;
(
  input  logic    i_sys_hclk,
  input  logic    i_sys_rst_b,
  input  logic    i_hsel,
  input  baddr_t  i_haddr,
  input  htrans_t i_htrans,
  input  hsize_t  i_hsize,
  input  logic    i_hwrite,
  input  word_t   i_hwdata,
  input  logic    i_little_endian,
  input  logic    i_rd_deny,
  input  logic    i_wr_deny,
  output word_t   o_hrdata,
  output logic    o_hready,
  output hresp_t  o_hresp,
  output logic    o_idle
);

  logic       hsel_g;
  htrans_t    htrans_g;
  logic       bank_hready;
  logic       ram_sel;
  logic       ram_write;
  hsize_t     ram_size;
  baddr_t     ram_addr;
  word_t      ram_wdata;
  word_t      ram_rdata;
  hsize_t     size_r;
  logic [1:0] addr_lo_r;
  logic       sel_r;

  sram_deny_guard u_deny_guard (
    .i_sys_hclk    (i_sys_hclk),
    .i_sys_rst_b   (i_sys_rst_b),
    .i_hsel        (i_hsel),
    .i_htrans      (i_htrans),
    .i_hwrite      (i_hwrite),
    .i_rd_deny     (i_rd_deny),
    .i_wr_deny     (i_wr_deny),
    .i_bank_hready (bank_hready),
    .o_hsel_g      (hsel_g),
    .o_htrans_g    (htrans_g),
    .o_hready      (o_hready),
    .o_hresp       (o_hresp)
  );

  sram_access_ctrl u_access_ctrl (
    .i_sys_hclk    (i_sys_hclk),
    .i_sys_rst_b   (i_sys_rst_b),
    .i_hsel        (hsel_g),
    .i_htrans      (htrans_g),
    .i_hwrite      (i_hwrite),
    .i_hsize       (i_hsize),
    .i_haddr       (i_haddr),
    .i_hready      (o_hready),  // final bus ready
    .o_ram_sel     (ram_sel),
    .o_ram_write   (ram_write),
    .o_ram_size    (ram_size),
    .o_ram_addr    (ram_addr),
    .o_size_r      (size_r),
    .o_addr_lo_r   (addr_lo_r),
    .o_sel_r       (sel_r),
    .o_bank_hready (bank_hready),
    .o_idle        (o_idle)
  );

  sram_lane_steer u_lane_steer (
    .i_little_endian (i_little_endian),
    .i_sel_r         (sel_r),
    .i_size_r        (size_r),
    .i_addr_lo_r     (addr_lo_r),
    .i_hwdata        (i_hwdata),
    .i_ram_rdata     (ram_rdata),
    .o_ram_wdata     (ram_wdata),
    .o_hrdata        (o_hrdata)
  );

  sram_byte_array u_byte_array (
    .i_sys_hclk  (i_sys_hclk),
    .i_sys_rst_b (i_sys_rst_b),
    .i_ram_sel   (ram_sel),
    .i_ram_write (ram_write),
    .i_ram_size  (ram_size),
    .i_ram_addr  (ram_addr),
    .i_ram_wdata (ram_wdata),
    .o_ram_rdata (ram_rdata)
  );

endmodule

/* sram_byte_array.sv */
/*
  SRAM word array with per-lane write enables and synchronous read;
  read data is forced to zero after a cycle without select
*/
`timescale 1ns/1ps
`include "sram_params.svh"

module sram_byte_array
  import sram_pkg::*;
(
  input  logic   i_sys_hclk,
  input  logic   i_sys_rst_b,
  input  logic   i_ram_sel,
  input  logic   i_ram_write,
  input  hsize_t i_ram_size,
  input  baddr_t i_ram_addr,
  input  word_t  i_ram_wdata,
  output word_t  o_ram_rdata
);

  word_t                   mem [0:(2**`SRAM_WADDR_W)-1];
  word_t                   rdata_q;
  logic                    sel_q;
  lane_en_t                lane_sel_b;
  lane_en_t                wen_b;
  logic [`SRAM_WADDR_W-1:0] waddr;

  assign waddr = i_ram_addr[`SRAM_ADDR_W-1:2];

  always_comb
  begin
    case (i_ram_size)
      `HSIZE_BYTE: lane_sel_b = ~(lane_en_t'(1) << i_ram_addr[1:0]);
      `HSIZE_HALF: lane_sel_b = i_ram_addr[1] ? 4'b0011 : 4'b1100;
      `HSIZE_WORD: lane_sel_b = '0;
      default:     lane_sel_b = '1;  // unsupported size writes nothing
    endcase
  end

  assign wen_b = lane_sel_b | {`SRAM_LANES{~i_ram_write}};

  always_ff @(posedge i_sys_hclk)
  begin
    if (i_ram_sel)
    begin
      for (int i = 0; i < `SRAM_LANES; i++)
      begin
        if (!wen_b[i])
          mem[waddr][i*8 +: 8] <= i_ram_wdata[i*8 +: 8];
      end
      if (!i_ram_write)
        rdata_q <= mem[waddr];
    end
  end

  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
      sel_q <= 1'b0;
    else
      sel_q <= i_ram_sel;
  end

  assign o_ram_rdata = sel_q ? rdata_q : '0;

endmodule

/* sram_deny_guard.sv */
/*
  SRAM deny guard: blocks transfers that hit a region deny flag
  and answers them with the two-cycle ERROR response
*/
`timescale 1ns/1ps
`include "sram_params.svh"

module sram_deny_guard
  import sram_pkg::*;
(
  input  logic    i_sys_hclk,
  input  logic    i_sys_rst_b,
  input  logic    i_hsel,
  input  htrans_t i_htrans,
  input  logic    i_hwrite,
  input  logic    i_rd_deny,
  input  logic    i_wr_deny,
  input  logic    i_bank_hready,
  output logic    o_hsel_g,
  output htrans_t o_htrans_g,
  output logic    o_hready,
  output hresp_t  o_hresp
);

  logic        act;
  logic        hit;
  deny_state_t state_q;
  deny_state_t state_d;

  assign act = i_hsel & ((i_htrans == `HTRANS_NONSEQ) | (i_htrans == `HTRANS_SEQ)) & o_hready;
  assign hit = act & (i_hwrite ? i_wr_deny : i_rd_deny);

  assign o_hsel_g   = i_hsel & ~hit;
  assign o_htrans_g = hit ? '0 : i_htrans;  // idle toward the bank

  always_comb
  begin
    case (state_q)
      DENY_IDLE: state_d = hit ? DENY_ERR1 : DENY_IDLE;
      DENY_ERR1: state_d = DENY_ERR2;
      DENY_ERR2: state_d = hit ? DENY_ERR1 : DENY_IDLE;  // back-to-back deny
      default:   state_d = DENY_IDLE;
    endcase
  end

  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
      state_q <= DENY_IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    case (state_q)
      DENY_ERR1:
      begin
        o_hready = 1'b0;
        o_hresp  = `HRESP_ERROR;
      end
      DENY_ERR2:
      begin
        o_hready = 1'b1;
        o_hresp  = `HRESP_ERROR;
      end
      default:
      begin
        o_hready = i_bank_hready;
        o_hresp  = `HRESP_OKAY;
      end
    endcase
  end

endmodule

/* sram_lane_steer.sv */
/*
  SRAM lane steering: mirrors byte and halfword lanes for a big-endian bus,
  separately for write data toward the array and read data toward the bus
*/
`timescale 1ns/1ps
`include "sram_params.svh"

module sram_lane_steer
  import sram_pkg::*;
(
  input  logic       i_little_endian,
  input  logic       i_sel_r,
  input  hsize_t     i_size_r,
  input  logic [1:0] i_addr_lo_r,
  input  word_t      i_hwdata,
  input  word_t      i_ram_rdata,
  output word_t      o_ram_wdata,
  output word_t      o_hrdata
);

  logic [4:0] byte_ofs;
  logic [4:0] byte_mir_ofs;
  logic [4:0] half_ofs;
  logic [4:0] half_mir_ofs;

  // bit offsets of the addressed lane and its mirror
  assign byte_ofs     = {i_addr_lo_r, 3'b000};
  assign byte_mir_ofs = {~i_addr_lo_r, 3'b000};
  assign half_ofs     = {i_addr_lo_r[1], 4'b0000};
  assign half_mir_ofs = {~i_addr_lo_r[1], 4'b0000};

  always_comb
  begin
    o_ram_wdata = i_hwdata;
    o_hrdata    = i_ram_rdata;
    if (i_sel_r && !i_little_endian)
    begin
      case (i_size_r)
        `HSIZE_BYTE:
        begin
          o_ram_wdata = '0;
          o_hrdata    = '0;
          o_ram_wdata[byte_ofs +: 8] = i_hwdata[byte_mir_ofs +: 8];
          o_hrdata[byte_mir_ofs +: 8] = i_ram_rdata[byte_ofs +: 8];
        end
        `HSIZE_HALF:
        begin
          o_ram_wdata = '0;
          o_hrdata    = '0;
          o_ram_wdata[half_ofs +: 16] = i_hwdata[half_mir_ofs +: 16];
          o_hrdata[half_mir_ofs +: 16] = i_ram_rdata[half_ofs +: 16];
        end
        default: ;  // word stays in place
      endcase
    end
  end

endmodule

/* sram_params.svh */
/*
  SRAM bank constants: bus widths, array depth and AHB transfer, size and response codes
*/
`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

`define SRAM_DATA_W    32
`define SRAM_LANES     4
`define SRAM_WADDR_W   10
`define SRAM_ADDR_W    (`SRAM_WADDR_W + 2)

`define HTRANS_NONSEQ  2'b10
`define HTRANS_SEQ     2'b11

`define HSIZE_BYTE     3'b000
`define HSIZE_HALF     3'b001
`define HSIZE_WORD     3'b010

`define HRESP_OKAY     2'b00
`define HRESP_ERROR    2'b01

`endif

/* sram_pkg.sv */
/*
  SRAM bank package: data, address and AHB field types shared by the bank blocks
*/
`include "sram_params.svh"

package sram_pkg;

  typedef logic [`SRAM_DATA_W-1:0] word_t;
  typedef logic [`SRAM_ADDR_W-1:0] baddr_t;   // byte address inside the bank
  typedef logic [`SRAM_LANES-1:0]  lane_en_t; // active low
  typedef logic [2:0]              hsize_t;
  typedef logic [1:0]              htrans_t;
  typedef logic [1:0]              hresp_t;

  // two-cycle error response sequence
  typedef enum logic [1:0] {
    DENY_IDLE,
    DENY_ERR1,
    DENY_ERR2
  } deny_state_t;

endpackage

/* src.f */
+incdir+.
sram_pkg.sv
sram_deny_guard.sv
sram_lane_steer.sv
sram_access_ctrl.sv
sram_byte_array.sv
sram_bank_top.sv
tb_clock_gen.sv
tb_sram_bank.sv

/* tb_clock_gen.sv */
/*
  testbench clock and reset generator for the SRAM bank
*/
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 16
)
(
  output logic o_clk,
  output logic o_rst_b
);

  initial
  begin
    o_clk   = 1'b0;
    o_rst_b = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_rst_b <= 1'b1;  // release on an edge
  end

  always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

/* tb_sram_bank.sv */
/*
  SRAM bank testbench: random AHB transfers against a byte-array memory model,
  endian mirroring, read-after-write stall, deny response and idle flag
*/
`timescale 1ns/1ps
`include "sram_params.svh"

module tb_sram_bank
  import sram_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int N_WORD       = 16;
  localparam int N_MERGE      = 6;
  localparam int N_PART       = 4;
  localparam int N_BE         = 8;
  localparam int N_RAW        = 4;
  localparam int RUN_CYCLES   = RESET_CYCLES + 12 + (2 * N_WORD + 6) +
                                (N_MERGE * (N_PART + 2) + 6) + (4 * N_BE + 14) +
                                (4 * N_RAW + 4) + 24 + 200;  // last term is margin

  logic    sys_hclk;
  logic    sys_rst_b;
  logic    hsel;
  baddr_t  haddr;
  htrans_t htrans;
  hsize_t  hsize;
  logic    hwrite;
  word_t   hwdata;
  logic    little_endian;
  logic    rd_deny;
  logic    wr_deny;
  word_t   hrdata;
  logic    hready;
  hresp_t  hresp;
  logic    idle;

  logic [7:0]  ref_mem [0:(2**`SRAM_ADDR_W)-1];
  logic        exp_chk_q [$];
  word_t       exp_data_q [$];
  hresp_t      exp_resp_q [$];
  logic [31:0] lcg_state = 32'hd687_8aa6;
  logic        le_mode;
  word_t       wdata_next;
  string       cur_test;
  int          err_count = 0;
  int          test_err_base;
  int          stall_cnt;
  int          tests_run = 0;
  int          tests_ok = 0;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
    .o_clk   (sys_hclk),
    .o_rst_b (sys_rst_b)
  );

  sram_bank_top UUT (
    .i_sys_hclk      (sys_hclk),
    .i_sys_rst_b     (sys_rst_b),
    .i_hsel          (hsel),
    .i_haddr         (haddr),
    .i_htrans        (htrans),
    .i_hsize         (hsize),
    .i_hwrite        (hwrite),
    .i_hwdata        (hwdata),
    .i_little_endian (little_endian),
    .i_rd_deny       (rd_deny),
    .i_wr_deny       (wr_deny),
    .o_hrdata        (hrdata),
    .o_hready        (hready),
    .o_hresp         (hresp),
    .o_idle          (idle)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic baddr_t rand_addr(input hsize_t sz);
    logic [31:0] r;
    baddr_t      a;
    r = lcg_next();
    a = r[8 +: `SRAM_ADDR_W];  // upper bits are the better ones
    if (sz == `HSIZE_WORD)
      a[1:0] = 2'b00;
    else if (sz == `HSIZE_HALF)
      a[0] = 1'b0;
    return a;
  endfunction

  // bytes land at their address; a big-endian bus carries them on the mirrored lane
  function automatic void model_write(input baddr_t a, input hsize_t sz, input word_t d,
                                      input logic le);
    int base;
    int lo;
    int h;
    int src;
    base = {a[`SRAM_ADDR_W-1:2], 2'b00};
    lo   = a[1:0];
    h    = a[1];
    case (sz)
      `HSIZE_BYTE:
      begin
        src        = le ? lo : 3 - lo;
        ref_mem[a] = d[src*8 +: 8];
      end
      `HSIZE_HALF:
      begin
        src                     = le ? h : 1 - h;
        ref_mem[base + 2*h]     = d[src*16 +: 8];
        ref_mem[base + 2*h + 1] = d[src*16 + 8 +: 8];
      end
      default:
      begin
        for (int i = 0; i < 4; i++)
          ref_mem[base + i] = d[i*8 +: 8];
      end
    endcase
  endfunction

  function automatic word_t expect_read(input baddr_t a, input hsize_t sz, input logic le);
    int    base;
    int    lo;
    int    h;
    word_t r;
    base = {a[`SRAM_ADDR_W-1:2], 2'b00};
    lo   = a[1:0];
    h    = a[1];
    r    = {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
    if (!le && sz == `HSIZE_BYTE)
    begin
      r                 = '0;
      r[(3 - lo)*8 +: 8] = ref_mem[a];
    end
    else if (!le && sz == `HSIZE_HALF)
    begin
      r                   = '0;
      r[(1 - h)*16 +: 16] = {ref_mem[base + 2*h + 1], ref_mem[base + 2*h]};
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act)
    else
    begin
      $display("FAILED %s: %s expected %h, actual %h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic wait_ready();
    @(negedge sys_hclk);
    while (!hready)
    begin
      stall_cnt++;
      @(negedge sys_hclk);
    end
  endtask

  // address phase of one transfer while the previous write data rides along
  task automatic issue(input logic wr, input hsize_t sz, input baddr_t a, input word_t wd,
                       input hresp_t resp);
    logic [31:0] t;
    t = lcg_next();
    @(posedge sys_hclk);
    hsel   <= 1'b1;
    htrans <= t[31] ? `HTRANS_SEQ : `HTRANS_NONSEQ;
    hwrite <= wr;
    hsize  <= sz;
    haddr  <= a;
    hwdata <= wdata_next;
    wait_ready();
    exp_resp_q.push_back(resp);
    exp_chk_q.push_back(!wr && resp == `HRESP_OKAY);
    if (wr)
    begin
      exp_data_q.push_back('0);
      if (resp == `HRESP_OKAY)
        model_write(a, sz, wd, le_mode);
      wdata_next = wd;
    end
    else
    begin
      exp_data_q.push_back(expect_read(a, sz, le_mode));
    end
  endtask

  task automatic finish_bus();
    @(posedge sys_hclk);
    hsel   <= 1'b0;
    htrans <= '0;
    hwrite <= 1'b0;
    hwdata <= wdata_next;
    wait_ready();
  endtask

  task automatic quiet_cycle();
    @(posedge sys_hclk);
    hsel   <= 1'b0;
    htrans <= '0;
    @(negedge sys_hclk);
  endtask

  task automatic set_mode(input logic le, input logic rdd, input logic wrd);
    @(posedge sys_hclk);
    little_endian <= le;
    rd_deny       <= rdd;
    wr_deny       <= wrd;
    le_mode = le;
    @(negedge sys_hclk);
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = err_count;
    stall_cnt     = 0;
  endtask

  task automatic end_test();
    @(posedge sys_hclk);  // let the compare process settle
    tests_run++;
    if (err_count == test_err_base)
    begin
      tests_ok++;
      $display("test %s: ok", cur_test);
    end
    else
    begin
      $display("test %s: %0d errors", cur_test, err_count - test_err_base);
    end
  endtask

  initial
  begin : compare_proc
    logic in_dphase;
    in_dphase = 1'b0;
    @(posedge sys_rst_b);
    forever
    begin
      @(negedge sys_hclk);
      if (in_dphase)
      begin
        check_value("hresp", 32'(exp_resp_q[0]), 32'(hresp));
        if (hready)
        begin
          if (exp_chk_q[0])
          begin
            check_value("hrdata", exp_data_q[0], hrdata);
          end
          void'(exp_resp_q.pop_front());
          void'(exp_chk_q.pop_front());
          void'(exp_data_q.pop_front());
          in_dphase = 1'b0;
        end
      end
      if (hsel && (htrans == `HTRANS_NONSEQ || htrans == `HTRANS_SEQ) && hready)
        in_dphase = 1'b1;
    end
  end

  initial
  begin : stimulus
    baddr_t      addrs [0:N_WORD-1];
    baddr_t      a;
    hsize_t      sz;
    word_t       d;
    logic [31:0] r;
    hsel          = 1'b0;
    haddr         = '0;
    htrans        = '0;
    hsize         = `HSIZE_WORD;
    hwrite        = 1'b0;
    hwdata        = '0;
    little_endian = 1'b1;
    rd_deny       = 1'b0;
    wr_deny       = 1'b0;
    le_mode       = 1'b1;
    wdata_next    = '0;
    @(posedge sys_rst_b);
    @(negedge sys_hclk);

    start_test("idle_flag");
    check_value("idle after reset", 1, 32'(idle));
    check_value("ready after reset", 1, 32'(hready));
    check_value("hresp after reset", `HRESP_OKAY, 32'(hresp));
    issue(1'b1, `HSIZE_WORD, '0, 32'h1234_5678, `HRESP_OKAY);
    check_value("idle in address phase", 0, 32'(idle));
    finish_bus();
    check_value("idle with posted write", 0, 32'(idle));
    quiet_cycle();
    check_value("idle on quiet bus", 1, 32'(idle));
    issue(1'b0, `HSIZE_WORD, '0, '0, `HRESP_OKAY);
    check_value("idle in address phase", 0, 32'(idle));
    finish_bus();
    check_value("idle after read", 1, 32'(idle));
    end_test();

    start_test("word_rw");
    for (int i = 0; i < N_WORD; i++)
    begin
      addrs[i] = rand_addr(`HSIZE_WORD);
      issue(1'b1, `HSIZE_WORD, addrs[i], lcg_next(), `HRESP_OKAY);
    end
    finish_bus();
    for (int i = 0; i < N_WORD; i++)
      issue(1'b0, `HSIZE_WORD, addrs[i], '0, `HRESP_OKAY);
    finish_bus();
    check_value("stall cycles", 0, stall_cnt);
    end_test();

    start_test("lane_merge");
    for (int i = 0; i < N_MERGE; i++)
    begin
      addrs[i] = rand_addr(`HSIZE_WORD);
      issue(1'b1, `HSIZE_WORD, addrs[i], lcg_next(), `HRESP_OKAY);  // known background
    end
    for (int i = 0; i < N_MERGE; i++)
    begin
      for (int j = 0; j < N_PART; j++)
      begin
        r  = lcg_next();
        sz = r[16] ? `HSIZE_HALF : `HSIZE_BYTE;
        a  = {addrs[i][`SRAM_ADDR_W-1:2], r[18:17]};
        if (sz == `HSIZE_HALF)
          a[0] = 1'b0;
        issue(1'b1, sz, a, lcg_next(), `HRESP_OKAY);
      end
    end
    finish_bus();
    for (int i = 0; i < N_MERGE; i++)
      issue(1'b0, `HSIZE_WORD, addrs[i], '0, `HRESP_OKAY);
    finish_bus();
    end_test();

    start_test("big_endian");
    set_mode(1'b0, 1'b0, 1'b0);
    for (int i = 0; i < N_BE; i++)
    begin
      addrs[i] = rand_addr(`HSIZE_BYTE);
      issue(1'b1, `HSIZE_BYTE, addrs[i], lcg_next(), `HRESP_OKAY);
    end
    finish_bus();
    for (int i = 0; i < N_BE; i++)
      issue(1'b0, `HSIZE_BYTE, addrs[i], '0, `HRESP_OKAY);
    finish_bus();
    for (int i = 0; i < N_BE; i++)
    begin
      addrs[i] = rand_addr(`HSIZE_HALF);
      issue(1'b1, `HSIZE_HALF, addrs[i], lcg_next(), `HRESP_OKAY);
    end
    finish_bus();
    for (int i = 0; i < N_BE; i++)
      issue(1'b0, `HSIZE_HALF, addrs[i], '0, `HRESP_OKAY);
    finish_bus();
    set_mode(1'b1, 1'b0, 1'b0);
    end_test();

    start_test("raw_stall");
    for (int i = 0; i < N_RAW; i++)
    begin
      a         = rand_addr(`HSIZE_WORD);
      stall_cnt = 0;
      issue(1'b1, `HSIZE_WORD, a, lcg_next(), `HRESP_OKAY);
      issue(1'b0, `HSIZE_WORD, a, '0, `HRESP_OKAY);  // meets the posted write
      finish_bus();
      check_value("stall cycles", 1, stall_cnt);
    end
    end_test();

    start_test("deny");
    a = rand_addr(`HSIZE_WORD);
    d = lcg_next();
    issue(1'b1, `HSIZE_WORD, a, d, `HRESP_OKAY);
    finish_bus();
    set_mode(1'b1, 1'b0, 1'b1);
    stall_cnt = 0;
    issue(1'b1, `HSIZE_WORD, a, ~d, `HRESP_ERROR);
    finish_bus();
    check_value("denied write stall cycles", 1, stall_cnt);
    set_mode(1'b1, 1'b1, 1'b0);
    stall_cnt = 0;
    issue(1'b0, `HSIZE_WORD, a, '0, `HRESP_ERROR);
    finish_bus();
    check_value("denied read stall cycles", 1, stall_cnt);
    set_mode(1'b1, 1'b0, 1'b0);
    issue(1'b0, `HSIZE_WORD, a, '0, `HRESP_OKAY);  // old word still there
    finish_bus();
    end_test();

    $display("%0d tests run, %0d ok, %0d check errors", tests_run, tests_ok, err_count);
    if (err_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial
  begin : watchdog
    #(RUN_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, run did not finish", RUN_CYCLES);
    $display("tests failed");
    $finish;
  end

endmodule
